//--- logic/rv_core_macros.svh
// rv core sizing macros
// shared data width, register count, reset vector and data memory depth
// for the single-cycle rv32i subset core

`ifndef RV_CORE_MACROS_SVH
`define RV_CORE_MACROS_SVH

// data and address width
`define RV_XLEN 32

// architectural integer registers
`define RV_REG_COUNT 32

// fetch address after reset
`define RV_PC_RESET 32'h0000_0000

// data store depth in 32-bit words
`define RV_DMEM_WORDS 256

`endif

//--- logic/rv_core_pkg.sv
// rv core shared types
// instruction format views overlaid on one fetched word
// plus the alu operation code passed from decode to execute

package rv_core_pkg;

  // register-register format
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } inst_r_t;

  // immediate format, addi and lw
  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } inst_i_t;

  // store format
  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } inst_s_t;

  // branch format with scattered offset bits
  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } inst_b_t;

  // upper immediate format, jal slices live in imm_31_12 too
  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } inst_u_t;

  // one word, five ways to read it
  typedef union packed {
    inst_r_t r;
    inst_i_t i;
    inst_s_t s;
    inst_b_t b;
    inst_u_t u;
  } inst_word_u;

  typedef enum logic [2:0] {
    ALU_ADD  = 3'd0,
    ALU_SUB  = 3'd1,
    ALU_AND  = 3'd2,
    ALU_OR   = 3'd3,
    ALU_XOR  = 3'd4,
    ALU_PASS = 3'd5
  } alu_op_t;

endpackage

//--- logic/inst_decode.sv
// instruction decoder
// splits the fetched word into register indices, immediate and control
// levels, and flags anything outside the supported subset as illegal

`include "rv_core_macros.svh"

module inst_decode import rv_core_pkg::*; (
  input  logic [31:0]        inst_data,
  output logic [4:0]         rs1,
  output logic [4:0]         rs2,
  output logic [4:0]         rd,
  output logic [`RV_XLEN-1:0] imm,
  output alu_op_t            alu_op,
  output logic               use_imm,
  output logic               use_pc,
  output logic               is_jal,
  output logic               is_beq,
  output logic               mem_read,
  output logic               mem_wen,
  output logic               reg_wen,
  output logic               is_ebreak,
  output logic               is_illegal
);

  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

  inst_word_u word;
  logic [19:0] j_bits;

  assign word   = inst_data;
  assign j_bits = word.u.imm_31_12;

  // register fields sit at the same spot in every format
  assign rs1 = word.r.rs1;
  assign rs2 = word.r.rs2;
  assign rd  = word.r.rd;

  // immediate format picked by opcode
  always_comb begin
    unique case (word.r.opcode)
      OP_IMM, OP_LOAD:
        imm = {{20{word.i.imm_11_0[11]}}, word.i.imm_11_0};
      OP_STORE:
        imm = {{20{word.s.imm_11_5[6]}}, word.s.imm_11_5, word.s.imm_4_0};
      OP_BRANCH:
        imm = {{19{word.b.imm_12}}, word.b.imm_12, word.b.imm_11,
               word.b.imm_10_5, word.b.imm_4_1, 1'b0};
      // jal offset bits are shuffled inside the upper field
      OP_JAL:
        imm = {{11{j_bits[19]}}, j_bits[19], j_bits[7:0], j_bits[8],
               j_bits[18:9], 1'b0};
      OP_LUI, OP_AUIPC:
        imm = {word.u.imm_31_12, 12'b0};
      default:
        imm = '0;
    endcase
  end

  always_comb begin
    // safe defaults, nothing written
    alu_op     = ALU_ADD;
    use_imm    = 1'b0;
    use_pc     = 1'b0;
    is_jal     = 1'b0;
    is_beq     = 1'b0;
    mem_read   = 1'b0;
    mem_wen    = 1'b0;
    reg_wen    = 1'b0;
    is_ebreak  = 1'b0;
    is_illegal = 1'b0;
    unique case (word.r.opcode)
      OP_LUI: begin
        alu_op  = ALU_PASS;
        use_imm = 1'b1;
        reg_wen = 1'b1;
      end
      OP_AUIPC: begin
        use_imm = 1'b1;
        use_pc  = 1'b1;
        reg_wen = 1'b1;
      end
      OP_JAL: begin
        is_jal  = 1'b1;
        reg_wen = 1'b1;
      end
      // only beq among branches
      OP_BRANCH: begin
        if (word.b.funct3 == 3'b000) is_beq = 1'b1;
        else is_illegal = 1'b1;
      end
      // lw only, word sized
      OP_LOAD: begin
        if (word.i.funct3 == 3'b010) begin
          use_imm  = 1'b1;
          mem_read = 1'b1;
          reg_wen  = 1'b1;
        end else begin
          is_illegal = 1'b1;
        end
      end
      OP_STORE: begin
        if (word.s.funct3 == 3'b010) begin
          use_imm = 1'b1;
          mem_wen = 1'b1;
        end else begin
          is_illegal = 1'b1;
        end
      end
      // addi only
      OP_IMM: begin
        if (word.i.funct3 == 3'b000) begin
          use_imm = 1'b1;
          reg_wen = 1'b1;
        end else begin
          is_illegal = 1'b1;
        end
      end
      OP_REG: begin
        reg_wen = 1'b1;
        unique case ({word.r.funct7, word.r.funct3})
          {7'b0000000, 3'b000}: alu_op = ALU_ADD;
          {7'b0100000, 3'b000}: alu_op = ALU_SUB;
          {7'b0000000, 3'b111}: alu_op = ALU_AND;
          {7'b0000000, 3'b110}: alu_op = ALU_OR;
          {7'b0000000, 3'b100}: alu_op = ALU_XOR;
          default: begin
            reg_wen    = 1'b0;
            is_illegal = 1'b1;
          end
        endcase
      end
      // ebreak must match the whole word
      OP_SYSTEM: begin
        if (inst_data == EBREAK_WORD) is_ebreak = 1'b1;
        else is_illegal = 1'b1;
      end
      default:
        is_illegal = 1'b1;
    endcase
  end

endmodule

//--- logic/alu_execute.sv
// execute stage
// picks operands, runs the alu, resolves beq and
// produces the next fetch address and the link address

`include "rv_core_macros.svh"

module alu_execute import rv_core_pkg::*; (
  input  logic [`RV_XLEN-1:0] pc,
  input  logic [`RV_XLEN-1:0] rdata_1,
  input  logic [`RV_XLEN-1:0] rdata_2,
  input  logic [`RV_XLEN-1:0] imm,
  input  alu_op_t             alu_op,
  input  logic                use_imm,
  input  logic                use_pc,
  input  logic                is_jal,
  input  logic                is_beq,
  output logic [`RV_XLEN-1:0] alu_result,
  output logic [`RV_XLEN-1:0] link_addr,
  output logic [`RV_XLEN-1:0] next_pc
);

  logic [`RV_XLEN-1:0] operand_1;
  logic [`RV_XLEN-1:0] operand_2;
  logic [`RV_XLEN-1:0] seq_pc;
  logic [`RV_XLEN-1:0] target_pc;
  logic                beq_taken;
  logic                redirect;

  // auipc adds to the pc
  assign operand_1 = use_pc ? pc : rdata_1;
  // immediate forms replace rs2
  assign operand_2 = use_imm ? imm : rdata_2;

  always_comb begin
    unique case (alu_op)
      ALU_ADD:  alu_result = operand_1 + operand_2;
      ALU_SUB:  alu_result = operand_1 - operand_2;
      ALU_AND:  alu_result = operand_1 & operand_2;
      ALU_OR:   alu_result = operand_1 | operand_2;
      ALU_XOR:  alu_result = operand_1 ^ operand_2;
      // lui just forwards the shifted immediate
      ALU_PASS: alu_result = operand_2;
      default:  alu_result = '0;
    endcase
  end

  // sequential and branch targets
  assign seq_pc    = pc + `RV_XLEN'd4;
  assign target_pc = pc + imm;

  // beq compares the raw register values
  assign beq_taken = is_beq && (rdata_1 == rdata_2);
  assign redirect  = is_jal || beq_taken;

  assign next_pc   = redirect ? target_pc : seq_pc;
  // jal writes the return address
  assign link_addr = seq_pc;

  // fetch must stay on word boundaries
  always_comb begin
    assert final (next_pc[1:0] == 2'b00)
      else $error("misaligned next pc %h from pc %h", next_pc, pc);
  end

endmodule

//--- logic/reg_writeback.sv
// register file and write-back select
// two combinational read ports, one write port on the commit edge
// x0 is hardwired to zero

`include "rv_core_macros.svh"

module reg_writeback (
  input  logic                clk,
  input  logic                arst_n,
  input  logic [4:0]          rs1,
  input  logic [4:0]          rs2,
  input  logic [4:0]          rd,
  input  logic                reg_wen,
  input  logic                mem_read,
  input  logic                is_jal,
  input  logic                commit,
  input  logic [`RV_XLEN-1:0] alu_result,
  input  logic [`RV_XLEN-1:0] link_addr,
  input  logic [`RV_XLEN-1:0] load_data,
  output logic [`RV_XLEN-1:0] rdata_1,
  output logic [`RV_XLEN-1:0] rdata_2,
  output logic [`RV_XLEN-1:0] wdata
);

  localparam int IDX_W = $clog2(`RV_REG_COUNT);

  logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];
  logic                write_en;

  // value going back, jal link beats load beats alu
  always_comb begin
    if (is_jal) begin
      wdata = link_addr;
    end else if (mem_read) begin
      wdata = load_data;
    end else begin
      wdata = alu_result;
    end
  end

  // never write x0
  assign write_en = commit && reg_wen && (rd != '0);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int idx = 0; idx < `RV_REG_COUNT; idx++) begin
        regs[idx] <= '0;
      end
    end else if (write_en) begin
      regs[rd[IDX_W-1:0]] <= wdata;
    end
  end

  // reads of x0 forced to zero
  assign rdata_1 = (rs1 == '0) ? '0 : regs[rs1[IDX_W-1:0]];
  assign rdata_2 = (rs2 == '0) ? '0 : regs[rs2[IDX_W-1:0]];

endmodule

//--- logic/data_memory.sv
// data memory
// word-addressed store, combinational read, write on the commit edge
// address wraps modulo the array depth

`include "rv_core_macros.svh"

module data_memory (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                commit,
  input  logic                mem_wen,
  input  logic [`RV_XLEN-1:0] addr,
  input  logic [`RV_XLEN-1:0] wdata,
  output logic [`RV_XLEN-1:0] load_data
);

  localparam int IDX_W = $clog2(`RV_DMEM_WORDS);

  logic [`RV_XLEN-1:0] mem [`RV_DMEM_WORDS];
  logic [IDX_W-1:0]    word_idx;

  // drop byte offset, upper bits wrap
  assign word_idx = addr[IDX_W+1:2];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int idx = 0; idx < `RV_DMEM_WORDS; idx++) begin
        mem[idx] <= '0;
      end
    end else if (commit && mem_wen) begin
      mem[word_idx] <= wdata;
    end
  end

  // lw sees the word in the same cycle
  assign load_data = mem[word_idx];

  // sw is word only
  store_aligned: assert property (
    @(posedge clk) disable iff (!arst_n)
    (commit && mem_wen) |-> (addr[1:0] == 2'b00)
  ) else $error("misaligned store to %h", addr);

endmodule

//--- logic/rv_core_top.sv
// single-cycle rv32i subset core
// holds the pc, halt and trap state, and the retire report
// fetch comes from outside, data memory sits inside

`include "rv_core_macros.svh"

module rv_core_top import rv_core_pkg::*; (
  input  logic                clk,
  input  logic                arst_n,
  output logic [`RV_XLEN-1:0] inst_addr,
  input  logic [31:0]         inst_data,
  output logic                retire_valid,
  output logic [`RV_XLEN-1:0] retire_pc,
  output logic [4:0]          retire_rd,
  output logic                retire_wen,
  output logic [`RV_XLEN-1:0] retire_wdata,
  output logic                halted,
  output logic                trapped
);

  logic [`RV_XLEN-1:0] pc;
  logic [`RV_XLEN-1:0] next_pc;
  logic [`RV_XLEN-1:0] imm;
  logic [`RV_XLEN-1:0] rdata_1;
  logic [`RV_XLEN-1:0] rdata_2;
  logic [`RV_XLEN-1:0] alu_result;
  logic [`RV_XLEN-1:0] link_addr;
  logic [`RV_XLEN-1:0] load_data;
  logic [`RV_XLEN-1:0] wdata;
  logic [4:0]          rs1;
  logic [4:0]          rs2;
  logic [4:0]          rd;
  alu_op_t             alu_op;
  logic                use_imm;
  logic                use_pc;
  logic                is_jal;
  logic                is_beq;
  logic                mem_read;
  logic                mem_wen;
  logic                reg_wen;
  logic                is_ebreak;
  logic                is_illegal;
  logic                commit;

  // the core runs until ebreak or a bad word
  assign commit    = !halted && !trapped;
  assign inst_addr = pc;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc           <= `RV_PC_RESET;
      halted       <= 1'b0;
      trapped      <= 1'b0;
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= commit;
      if (commit) begin
        pc <= next_pc;
        // both states are sticky until the next reset
        if (is_ebreak) halted <= 1'b1;
        if (is_illegal) trapped <= 1'b1;
      end
    end
  end

  // retire fields only meaningful with retire_valid
  always_ff @(posedge clk) begin
    if (commit) begin
      retire_pc    <= pc;
      retire_rd    <= rd;
      retire_wen   <= reg_wen && (rd != '0);
      retire_wdata <= wdata;
    end
  end

  inst_decode inst_decode_inst (
    .inst_data  (inst_data),
    .rs1        (rs1),
    .rs2        (rs2),
    .rd         (rd),
    .imm        (imm),
    .alu_op     (alu_op),
    .use_imm    (use_imm),
    .use_pc     (use_pc),
    .is_jal     (is_jal),
    .is_beq     (is_beq),
    .mem_read   (mem_read),
    .mem_wen    (mem_wen),
    .reg_wen    (reg_wen),
    .is_ebreak  (is_ebreak),
    .is_illegal (is_illegal)
  );

  alu_execute alu_execute_inst (
    .pc         (pc),
    .rdata_1    (rdata_1),
    .rdata_2    (rdata_2),
    .imm        (imm),
    .alu_op     (alu_op),
    .use_imm    (use_imm),
    .use_pc     (use_pc),
    .is_jal     (is_jal),
    .is_beq     (is_beq),
    .alu_result (alu_result),
    .link_addr  (link_addr),
    .next_pc    (next_pc)
  );

  reg_writeback reg_writeback_inst (
    .clk        (clk),
    .arst_n     (arst_n),
    .rs1        (rs1),
    .rs2        (rs2),
    .rd         (rd),
    .reg_wen    (reg_wen),
    .mem_read   (mem_read),
    .is_jal     (is_jal),
    .commit     (commit),
    .alu_result (alu_result),
    .link_addr  (link_addr),
    .load_data  (load_data),
    .rdata_1    (rdata_1),
    .rdata_2    (rdata_2),
    .wdata      (wdata)
  );

  // store data comes straight from rs2
  data_memory data_memory_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .commit    (commit),
    .mem_wen   (mem_wen),
    .addr      (alu_result),
    .wdata     (rdata_2),
    .load_data (load_data)
  );

endmodule

//--- bench/rv_core_tb.sv
// testbench for the single-cycle rv32i subset core
// builds two random programs, runs them from a behavioral instruction memory
// and checks every retire against a reference model with assertions

`include "rv_core_macros.svh"

module rv_core_tb;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 10;
  localparam int IDLE_CYCLES  = 8;
  localparam int DRIVE_DLY    = 10;
  localparam int MODEL_DLY    = 20;
  // 256 words, indexed by address bits 9:2
  localparam int IMEM_WORDS   = 256;

  // own copy of the encodings
  localparam logic [6:0]  OPC_LUI     = 7'b0110111;
  localparam logic [6:0]  OPC_AUIPC   = 7'b0010111;
  localparam logic [6:0]  OPC_JAL     = 7'b1101111;
  localparam logic [6:0]  OPC_BRANCH  = 7'b1100011;
  localparam logic [6:0]  OPC_LOAD    = 7'b0000011;
  localparam logic [6:0]  OPC_STORE   = 7'b0100011;
  localparam logic [6:0]  OPC_IMM     = 7'b0010011;
  localparam logic [6:0]  OPC_REG     = 7'b0110011;
  localparam logic [6:0]  OPC_SYSTEM  = 7'b1110011;
  localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

  logic                clk;
  logic                arst_n;
  logic [`RV_XLEN-1:0] inst_addr;
  logic [31:0]         inst_data;
  logic                retire_valid;
  logic [`RV_XLEN-1:0] retire_pc;
  logic [4:0]          retire_rd;
  logic                retire_wen;
  logic [`RV_XLEN-1:0] retire_wdata;
  logic                halted;
  logic                trapped;

  logic [31:0] imem [IMEM_WORDS];
  logic [31:0] prog_run [$];
  logic [31:0] prog_trap [$];
  logic [31:0] lfsr;
  logic        programs_ready;
  int          mismatch_count;
  int          other_count;

  // reference model state
  logic [31:0] m_pc;
  logic [31:0] m_regs [`RV_REG_COUNT];
  logic [31:0] m_mem [`RV_DMEM_WORDS];
  logic [31:0] exp_pc;
  logic [4:0]  exp_rd;
  logic        exp_wen;
  logic [31:0] exp_wdata;
  logic        exp_halted;
  logic        exp_trapped;

  rv_core_top rv_core_top_inst (
    .clk          (clk),
    .arst_n       (arst_n),
    .inst_addr    (inst_addr),
    .inst_data    (inst_data),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_rd    (retire_rd),
    .retire_wen   (retire_wen),
    .retire_wdata (retire_wdata),
    .halted       (halted),
    .trapped      (trapped)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // fetch answers a little after each edge
  initial begin
    inst_data = '0;
    forever begin
      @(posedge clk);
      #DRIVE_DLY;
      inst_data = imem[inst_addr[9:2]];
    end
  end

  // x^32 + x^22 + x^2 + x + 1, new bit enters at bit 0
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] take_bits(input int count);
    logic [31:0] bits;
    bits = '0;
    for (int n = 0; n < count; n++) begin
      lfsr = lfsr_next(lfsr);
      bits = {bits[30:0], lfsr[0]};
    end
    return bits;
  endfunction

  function automatic logic [31:0] i_word(input logic [6:0] opcode, input logic [11:0] imm,
                                         input logic [4:0] rs1, input logic [2:0] funct3,
                                         input logic [4:0] rd);
    return {imm, rs1, funct3, rd, opcode};
  endfunction

  function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [11:0] imm);
    return i_word(OPC_IMM, imm, rs1, 3'b000, rd);
  endfunction

  // store word, funct3 fixed to sw
  function automatic logic [31:0] s_word(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
  endfunction

  // beq with byte offset
  function automatic logic [31:0] b_word(input logic [12:0] off, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
    return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] u_word(input logic [6:0] opcode, input logic [19:0] imm,
                                         input logic [4:0] rd);
    return {imm, rd, opcode};
  endfunction

  function automatic logic [31:0] j_word(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
  endfunction

  // sel 0..4 is add, sub, and, or, xor
  function automatic logic [31:0] alu_word(input int sel, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2);
    logic [6:0] funct7;
    logic [2:0] funct3;
    funct7 = 7'b0000000;
    funct3 = 3'b000;
    case (sel)
      1: funct7 = 7'b0100000;
      2: funct3 = 3'b111;
      3: funct3 = 3'b110;
      4: funct3 = 3'b100;
      default: funct3 = 3'b000;
    endcase
    return {funct7, rs2, rs1, funct3, rd, OPC_REG};
  endfunction

  task automatic build_run_program();
    logic [31:0] rnd;
    logic [31:0] addr_a;
    int          sel;
    int          skip;
    // random 32-bit values in x1..x8
    for (int r = 1; r <= 8; r++) begin
      rnd = take_bits(20);
      prog_run.push_back(u_word(OPC_LUI, rnd[19:0], 5'(r)));
      rnd = take_bits(12);
      prog_run.push_back(addi_word(5'(r), 5'(r), rnd[11:0]));
    end
    // random register mix, rd can land on x0
    for (int k = 0; k < 12; k++) begin
      rnd = take_bits(3);
      sel = rnd % 5;
      rnd = take_bits(12);
      prog_run.push_back(alu_word(sel, {1'b0, rnd[3:0]}, {1'b0, rnd[7:4]},
                                  {1'b0, rnd[11:8]}));
    end
    // x0 write, then read it back
    prog_run.push_back(addi_word(5'd0, 5'd1, 12'h055));
    prog_run.push_back(alu_word(0, 5'd9, 5'd0, 5'd1));
    rnd = take_bits(20);
    prog_run.push_back(u_word(OPC_AUIPC, rnd[19:0], 5'd20));
    // jal over one or two marker words
    rnd = take_bits(1);
    skip = rnd[0] ? 3 : 2;
    prog_run.push_back(j_word(21'(skip * 4), 5'd21));
    for (int n = 1; n < skip; n++) begin
      prog_run.push_back(addi_word(5'd22, 5'd0, 12'h7ff));
    end
    // beq taken skips a marker
    rnd = take_bits(12);
    prog_run.push_back(addi_word(5'd23, 5'd0, rnd[11:0]));
    prog_run.push_back(addi_word(5'd24, 5'd0, rnd[11:0]));
    prog_run.push_back(b_word(13'd8, 5'd24, 5'd23));
    prog_run.push_back(addi_word(5'd25, 5'd0, 12'h7ff));
    // beq not taken once the values differ
    prog_run.push_back(addi_word(5'd24, 5'd24, 12'd1));
    prog_run.push_back(b_word(13'd8, 5'd24, 5'd23));
    prog_run.push_back(addi_word(5'd25, 5'd0, 12'h123));
    // two word addresses, 0x80 apart
    rnd = take_bits(9);
    addr_a = {21'b0, rnd[8:0], 2'b00};
    prog_run.push_back(addi_word(5'd26, 5'd0, addr_a[11:0]));
    prog_run.push_back(addi_word(5'd27, 5'd26, 12'h080));
    prog_run.push_back(s_word(12'd0, 5'd1, 5'd26));
    prog_run.push_back(s_word(12'd0, 5'd2, 5'd27));
    prog_run.push_back(s_word(12'd4, 5'd4, 5'd26));
    // overwrite the first word
    prog_run.push_back(s_word(12'd0, 5'd3, 5'd26));
    prog_run.push_back(i_word(OPC_LOAD, 12'd0, 5'd26, 3'b010, 5'd28));
    prog_run.push_back(i_word(OPC_LOAD, 12'd0, 5'd27, 3'b010, 5'd29));
    prog_run.push_back(i_word(OPC_LOAD, 12'd4, 5'd26, 3'b010, 5'd30));
    prog_run.push_back(EBREAK_WORD);
  endtask

  task automatic build_trap_program();
    logic [31:0] rnd;
    for (int r = 1; r <= 4; r++) begin
      rnd = take_bits(12);
      prog_trap.push_back(addi_word(5'(r), 5'd0, rnd[11:0]));
    end
    // one word outside the subset
    rnd = take_bits(22);
    case (rnd[21:20])
      2'd0: prog_trap.push_back({7'b0000001, 5'd2, 5'd1, 3'b000, 5'd5, OPC_REG});
      2'd1: prog_trap.push_back(i_word(OPC_IMM, 12'h003, 5'd1, 3'b001, 5'd5));
      2'd2: prog_trap.push_back(i_word(OPC_LOAD, 12'h000, 5'd0, 3'b000, 5'd5));
      default: prog_trap.push_back(u_word(7'b0001011, rnd[19:0], 5'd5));
    endcase
    // never reached
    prog_trap.push_back(addi_word(5'd5, 5'd0, 12'h0ff));
    prog_trap.push_back(addi_word(5'd1, 5'd0, 12'h0ff));
    prog_trap.push_back(EBREAK_WORD);
  endtask

  task automatic load_program(input logic [31:0] words [$]);
    // stray fetches hit an illegal opcode tagged with the word index
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = {i[24:0], 7'b1111111};
    end
    foreach (words[i]) begin
      imem[i] = words[i];
    end
  endtask

  task automatic model_reset();
    m_pc = `RV_PC_RESET;
    for (int r = 0; r < `RV_REG_COUNT; r++) begin
      m_regs[r] = '0;
    end
    for (int w = 0; w < `RV_DMEM_WORDS; w++) begin
      m_mem[w] = '0;
    end
    exp_pc      = `RV_PC_RESET;
    exp_rd      = '0;
    exp_wen     = 1'b0;
    exp_wdata   = '0;
    exp_halted  = 1'b0;
    exp_trapped = 1'b0;
  endtask

  // executes the word at m_pc and sets the expected retire
  task automatic model_retire();
    logic [31:0] word;
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic [31:0] i_imm;
    logic [31:0] value;
    logic [31:0] next_pc;
    logic [31:0] addr;
    logic        writes;
    logic        bad;
    word    = imem[m_pc[9:2]];
    rs1_val = m_regs[word[19:15]];
    rs2_val = m_regs[word[24:20]];
    i_imm   = {{20{word[31]}}, word[31:20]};
    value   = '0;
    writes  = 1'b0;
    bad     = 1'b0;
    next_pc = m_pc + 32'd4;
    case (word[6:0])
      OPC_LUI: begin
        value  = {word[31:12], 12'b0};
        writes = 1'b1;
      end
      OPC_AUIPC: begin
        value  = m_pc + {word[31:12], 12'b0};
        writes = 1'b1;
      end
      OPC_JAL: begin
        value   = m_pc + 32'd4;
        writes  = 1'b1;
        next_pc = m_pc + {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
      end
      OPC_BRANCH: begin
        if (word[14:12] != 3'b000) begin
          bad = 1'b1;
        end else if (rs1_val == rs2_val) begin
          next_pc = m_pc + {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
        end
      end
      OPC_LOAD: begin
        addr   = rs1_val + i_imm;
        value  = m_mem[addr[9:2]];
        writes = (word[14:12] == 3'b010);
        bad    = !writes;
      end
      OPC_STORE: begin
        addr = rs1_val + {{20{word[31]}}, word[31:25], word[11:7]};
        if (word[14:12] == 3'b010) begin
          m_mem[addr[9:2]] = rs2_val;
        end else begin
          bad = 1'b1;
        end
      end
      OPC_IMM: begin
        value  = rs1_val + i_imm;
        writes = (word[14:12] == 3'b000);
        bad    = !writes;
      end
      OPC_REG: begin
        writes = 1'b1;
        case ({word[31:25], word[14:12]})
          10'b0000000_000: value = rs1_val + rs2_val;
          10'b0100000_000: value = rs1_val - rs2_val;
          10'b0000000_111: value = rs1_val & rs2_val;
          10'b0000000_110: value = rs1_val | rs2_val;
          10'b0000000_100: value = rs1_val ^ rs2_val;
          default: begin
            writes = 1'b0;
            bad    = 1'b1;
          end
        endcase
      end
      OPC_SYSTEM: begin
        if (word == EBREAK_WORD) exp_halted = 1'b1;
        else bad = 1'b1;
      end
      default: bad = 1'b1;
    endcase
    exp_pc    = m_pc;
    exp_rd    = word[11:7];
    exp_wen   = writes && !bad && (word[11:7] != 5'd0);
    exp_wdata = value;
    if (exp_wen) m_regs[word[11:7]] = value;
    if (bad) exp_trapped = 1'b1;
    m_pc = next_pc;
  endtask

  // model steps after the retire registers settle
  always @(posedge clk) begin
    #MODEL_DLY;
    if (!arst_n) model_reset();
    else if (retire_valid) model_retire();
  end

  task automatic report_mismatch(input string test_name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    mismatch_count++;
    $display("FAILED %s: expected %h, actual %h at time %0t", test_name, expected,
             actual, $time);
  endtask

  task automatic report_problem(input string what);
    other_count++;
    $display("ERROR: %s at time %0t", what, $time);
  endtask

  task automatic wait_for_stop();
    while (!halted && !trapped) @(posedge clk);
  endtask

  task automatic compare_registers(input string test_name);
    logic [31:0] actual;
    for (int r = 0; r < `RV_REG_COUNT; r++) begin
      actual = rv_core_top_inst.reg_writeback_inst.regs[r];
      assert (actual == m_regs[r])
        else report_mismatch($sformatf("%s x%0d", test_name, r), m_regs[r], actual);
    end
  endtask

  // checks at the falling edge, where everything is stable
  reset_quiet: assert property (@(negedge clk)
    !arst_n |-> (!retire_valid && !halted && !trapped && inst_addr == `RV_PC_RESET))
    else report_problem("core active or off the reset vector while reset is held");

  reset_release_fetch: assert property (@(negedge clk)
    $rose(arst_n) |-> inst_addr == `RV_PC_RESET)
    else report_mismatch("fetch after reset", `RV_PC_RESET, inst_addr);

  retire_pc_match: assert property (@(negedge clk) disable iff (!arst_n)
    retire_valid |-> retire_pc == exp_pc)
    else report_mismatch("retire pc", exp_pc, retire_pc);

  retire_wen_match: assert property (@(negedge clk) disable iff (!arst_n)
    retire_valid |-> retire_wen == exp_wen)
    else report_mismatch("retire write enable", 32'(exp_wen), 32'(retire_wen));

  retire_rd_match: assert property (@(negedge clk) disable iff (!arst_n)
    (retire_valid && exp_wen) |-> retire_rd == exp_rd)
    else report_mismatch("retire rd", 32'(exp_rd), 32'(retire_rd));

  retire_wdata_match: assert property (@(negedge clk) disable iff (!arst_n)
    (retire_valid && exp_wen) |-> retire_wdata == exp_wdata)
    else report_mismatch("retire write data", exp_wdata, retire_wdata);

  halted_match: assert property (@(negedge clk) disable iff (!arst_n)
    halted == exp_halted)
    else report_mismatch("halted", 32'(exp_halted), 32'(halted));

  trapped_match: assert property (@(negedge clk) disable iff (!arst_n)
    trapped == exp_trapped)
    else report_mismatch("trapped", 32'(exp_trapped), 32'(trapped));

  // a stopped core stays silent
  stopped_silent: assert property (@(negedge clk) disable iff (!arst_n)
    ((halted || trapped) && $past(halted || trapped)) |-> !retire_valid)
    else report_problem("instruction retired after halt or trap");

  stopped_fetch_hold: assert property (@(negedge clk) disable iff (!arst_n)
    $past(halted || trapped) |-> $stable(inst_addr))
    else report_problem("fetch address moved after halt or trap");

  initial begin : watchdog
    longint limit_cycles;
    wait (programs_ready);
    limit_cycles = prog_run.size() + prog_trap.size() + 2 * (RESET_CYCLES + IDLE_CYCLES) + 50;
    #(limit_cycles * CLK_PERIOD);
    $display("watchdog: run did not finish within %0d cycles", limit_cycles);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    arst_n         = 1'b0;
    mismatch_count = 0;
    other_count    = 0;
    programs_ready = 1'b0;
    lfsr           = 32'hbdd02d83;
    build_run_program();
    build_trap_program();
    load_program(prog_run);
    programs_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    arst_n = 1'b1;
    wait_for_stop();
    repeat (IDLE_CYCLES) @(posedge clk);
    @(negedge clk);
    compare_registers("run program");
    // second program after a fresh reset
    @(posedge clk);
    #DRIVE_DLY;
    arst_n = 1'b0;
    load_program(prog_trap);
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    arst_n = 1'b1;
    wait_for_stop();
    repeat (IDLE_CYCLES) @(posedge clk);
    @(negedge clk);
    compare_registers("trap program");
    $display("errors: %0d value mismatches, %0d other failures", mismatch_count,
             other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- rv_core.f
+incdir+logic
logic/rv_core_pkg.sv
logic/inst_decode.sv
logic/alu_execute.sv
logic/reg_writeback.sv
logic/data_memory.sv
logic/rv_core_top.sv
bench/rv_core_tb.sv

//--- Makefile
# Verilator flow for the rv core
# make lint, make sim, make clean; any variable can be set on the command line

VERILATOR  ?= verilator
TOP        ?= rv_core_tb
RTL_TOP    ?= rv_core_top
FILELIST   ?= rv_core.f
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?=
PASS_TEXT  ?= SIMULATION PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary --assert $(SIM_FLAGS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -F "$(PASS_TEXT)" > /dev/null

clean:
	rm -rf $(OBJ_DIR)
